//--- run.sh
#!/bin/sh
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_writeback -f tb.f -o tb_writeback
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed"
   exit $status
fi

# keep running past assertion errors so the testbench reports them
./obj_dir/tb_writeback +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0

//--- tb.f
verilog/wb_pkg.sv
verilog/wb_flags.sv
verilog/wb_operand_select.sv
verilog/wb_commit.sv
verilog/writeback.sv
verif/wb_chk.sv
verif/tb_writeback.sv

//--- verif/tb_writeback.sv
`timescale 1ns/1ps

module tb_writeback;

   // directed sequence runs well under a hundred cycles
   localparam int TIMEOUT_CYCLES = 2000;
   localparam logic [31:0] ALU_MASK = 32'h0000_08d5;

   logic clk;
   logic arst_n;
   wb_pkg::wb_in_t     wb_in;
   logic               write_ready;
   wb_pkg::wb_gpr_wr_t gpr1;
   wb_pkg::wb_gpr_wr_t gpr2;
   wb_pkg::wb_gpr_wr_t gpr3;
   logic [1:0]         datasize;
   logic [1:0]         dr3_datasize;
   logic               ld_seg;
   logic [63:0]        mm_data;
   logic               ld_mm;
   logic [31:0]        eip;
   logic               ld_eip;
   logic [15:0]        cs;
   logic               ld_cs;
   wb_pkg::wb_flags_u  flags_out;
   logic               ld_flags;
   logic [63:0]        dcache_data;
   logic [31:0]        dcache_address;
   logic               dcache_write;
   wb_pkg::wb_commit_t dep;
   logic               halt;
   logic               repne_terminate;
   logic               stall;
   wb_pkg::wb_flags_u  flags_fwd;
   logic [31:0]        count_fwd;

   logic [31:0] rng_state;
   logic [31:0] model_flags;
   int          cycles = 0;

   writeback i_dut (.*);

   initial clk = 1'b0;
   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("CHECKS FAILED");
         $fatal(1, "timeout after %0d cycles", cycles);
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic wb_pkg::wb_in_t valid_op();
      valid_op = '0;
      valid_op.valid = 1'b1;
   endfunction

   task automatic abort_run(input string why);
      $display("CHECKS FAILED");
      $fatal(1, "%s", why);
   endtask

   task automatic check_commit(input string name, input wb_pkg::wb_commit_t got,
                               input wb_pkg::wb_commit_t exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run("qualified loads differ");
      end
   endtask

   task automatic check_flags(input string name, input wb_pkg::wb_flags_u got,
                              input wb_pkg::wb_flags_u exp);
      if (got.raw !== exp.raw) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got.raw, exp.raw);
         abort_run("flags value differs");
      end
   endtask

   task automatic check_word(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run("data value differs");
      end
   endtask

   task automatic check_gpr(input string name, input wb_pkg::wb_gpr_wr_t got,
                            input wb_pkg::wb_gpr_wr_t exp);
      if (got !== exp) begin
         $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run("register write port differs");
      end
   endtask

   // new inputs settle 2 ns after the edge, sampled there
   task automatic drive(input wb_pkg::wb_in_t op, input logic ready);
      @(posedge clk);
      #1;
      wb_in = op;
      write_ready = ready;
      #1;
   endtask

   task automatic load_flags(input logic [31:0] value);
      wb_pkg::wb_in_t    op;
      wb_pkg::wb_flags_u exp_f;
      op = valid_op();
      op.ctrl.pop_flags = 1'b1;
      op.ctrl.ld_flags = 1'b1;
      op.result_a = value;
      exp_f.raw = value;
      drive(op, 1'b1);
      check_flags("flags_fwd", flags_fwd, exp_f);
      check_flags("flags_out", flags_out, exp_f);
      model_flags = value;
   endtask

   task automatic test_alu_mem();
      wb_pkg::wb_in_t     op;
      wb_pkg::wb_commit_t exp_c;
      op = valid_op();
      op.ld_gpr1 = 1'b1;
      op.ld_gpr2 = 1'b1;
      op.ctrl.ld_gpr3 = 1'b1;
      op.ctrl.ld_seg = 1'b1;
      op.ctrl.ld_mm = 1'b1;
      op.dr1 = 3'd1;
      op.dr2 = 3'd5;
      op.dr3 = 3'd7;
      op.datasize = 2'b01;
      op.result_a = next_rand();
      op.result_b = next_rand();
      op.result_c = next_rand();
      drive(op, 1'b1);
      check_gpr("gpr1", gpr1, wb_pkg::wb_gpr_wr_t'{1'b1, 3'd1, op.result_a});
      check_gpr("gpr2", gpr2, wb_pkg::wb_gpr_wr_t'{1'b1, 3'd5, op.result_b});
      check_gpr("gpr3", gpr3, wb_pkg::wb_gpr_wr_t'{1'b1, 3'd7, op.result_c});
      check_word("datasize", 64'(datasize), 64'(2'b01));
      check_word("dr3_datasize", 64'(dr3_datasize), 64'(2'b10));
      check_word("count_fwd", 64'(count_fwd), 64'(op.result_c));
      check_word("ld_seg", 64'(ld_seg), 64'd1);
      check_word("ld_mm", 64'(ld_mm), 64'd1);
      exp_c = '0;
      exp_c.ld_gpr1 = 1'b1;
      exp_c.ld_gpr2 = 1'b1;
      exp_c.ld_gpr3 = 1'b1;
      exp_c.ld_seg = 1'b1;
      exp_c.ld_mm = 1'b1;
      check_commit("dep", dep, exp_c);
      op.valid = 1'b0;
      drive(op, 1'b1);
      check_gpr("gpr1", gpr1, wb_pkg::wb_gpr_wr_t'{1'b0, 3'd1, op.result_a});
      check_word("ld_seg", 64'(ld_seg), 64'd0);
      check_word("ld_mm", 64'(ld_mm), 64'd0);
      check_commit("dep", dep, '0);
      op = valid_op();
      op.dcache_write = 1'b1;
      op.address = next_rand();
      op.result_a = next_rand();
      op.result_mm = {next_rand(), next_rand()};
      drive(op, 1'b1);
      check_word("dcache_address", 64'(dcache_address), 64'(op.address));
      check_word("dcache_data", dcache_data, {32'd0, op.result_a});
      check_word("dcache_write", 64'(dcache_write), 64'd1);
      check_word("stall", 64'(stall), 64'd0);
      op.ctrl.mm_mem = 1'b1;
      drive(op, 1'b1);
      check_word("dcache_data", dcache_data, op.result_mm);
      check_word("mm_data", mm_data, op.result_mm);
   endtask

   task automatic test_flags();
      wb_pkg::wb_in_t    op;
      logic [31:0]       exp;
      wb_pkg::wb_flags_u exp_f;
      op = valid_op();
      op.ctrl.ld_flags = 1'b1;
      op.ctrl.is_jne = 1'b1;
      op.ctrl.ld_eip = 1'b1;
      op.flags.raw = next_rand() | 32'h40;
      exp = (op.flags.raw & ALU_MASK) | (model_flags & ~ALU_MASK);
      exp_f.raw = exp;
      drive(op, 1'b1);
      check_flags("flags_fwd", flags_fwd, exp_f);
      check_flags("flags_out", flags_out, exp_f);
      check_word("ld_flags", 64'(ld_flags), 64'd1);
      // the jump still sees the old zf
      check_word("ld_eip", 64'(ld_eip), 64'(!model_flags[6]));
      model_flags = exp;
      op = valid_op();
      op.ctrl.is_jne = 1'b1;
      op.ctrl.ld_eip = 1'b1;
      op.neip = next_rand();
      drive(op, 1'b1);
      check_word("ld_eip", 64'(ld_eip), 64'(!model_flags[6]));
      check_word("eip", 64'(eip), 64'(op.neip));
      // pushf stores the outgoing flags word
      op = valid_op();
      op.ctrl.push_flags = 1'b1;
      op.dcache_write = 1'b1;
      op.result_a = next_rand();
      op.flags.raw = next_rand();
      exp = (op.flags.raw & ALU_MASK) | (model_flags & ~ALU_MASK);
      drive(op, 1'b1);
      check_word("dcache_data", dcache_data, {32'd0, exp});
      load_flags(next_rand());
   endtask

   task automatic test_conditions();
      wb_pkg::wb_in_t op;
      logic [31:0]    cases [4];
      cases = '{32'h2, 32'h3, 32'h42, 32'h43};
      for (int i = 0; i < 4; i++) begin
         load_flags(cases[i]);
         op = valid_op();
         op.ctrl.ld_eip = 1'b1;
         op.ctrl.is_jne = 1'b1;
         drive(op, 1'b1);
         check_word("ld_eip jne", 64'(ld_eip), 64'(!cases[i][6]));
         op.ctrl.is_jne = 1'b0;
         op.ctrl.is_jnbe = 1'b1;
         drive(op, 1'b1);
         check_word("ld_eip jnbe", 64'(ld_eip), 64'(!cases[i][6] && !cases[i][0]));
         op = valid_op();
         op.ld_gpr2 = 1'b1;
         op.ctrl.is_cmovc = 1'b1;
         op.dr2 = 3'd3;
         op.result_b = next_rand();
         drive(op, 1'b1);
         check_gpr("gpr2 cmovc", gpr2, wb_pkg::wb_gpr_wr_t'{cases[i][0], 3'd3, op.result_b});
      end
   endtask

   task automatic test_cmps();
      wb_pkg::wb_in_t     op;
      wb_pkg::wb_commit_t exp_c;
      logic [31:0]        saved;
      logic               term;
      load_flags(32'h2);
      saved = next_rand();
      op = valid_op();
      op.ctrl.is_cmps_first = 1'b1;
      op.result_a = saved;
      drive(op, 1'b1);
      // zf match, count exhausted, then neither
      for (int i = 0; i < 3; i++) begin
         op = valid_op();
         op.ctrl.is_cmps_second = 1'b1;
         op.repne = 1'b1;
         op.ld_gpr1 = 1'b1;
         op.ctrl.ld_gpr3 = 1'b1;
         op.ctrl.ld_flags = 1'b1;
         op.result_a = next_rand();
         op.result_c = (i == 1) ? 32'd0 : (next_rand() | 32'd1);
         op.flags.raw = (i == 0) ? 32'h40 : 32'h0;
         term = (i != 2);
         drive(op, 1'b1);
         check_word("repne_terminate", 64'(repne_terminate), 64'(term));
         check_gpr("gpr1", gpr1, wb_pkg::wb_gpr_wr_t'{!term, 3'd0, saved});
         exp_c = '0;
         exp_c.ld_gpr1 = !term;
         exp_c.ld_gpr3 = !term;
         exp_c.ld_flags = !term;
         check_commit("dep", dep, exp_c);
         if (!term) begin
            model_flags = (op.flags.raw & ALU_MASK) | (model_flags & ~ALU_MASK);
         end
      end
   endtask

   task automatic test_saved_and_halt();
      wb_pkg::wb_in_t op;
      logic [31:0]    saved_neip;
      logic [31:0]    tmp;
      op = valid_op();
      op.ctrl.save_neip = 1'b1;
      op.ctrl.save_ncs = 1'b1;
      op.neip = next_rand();
      tmp = next_rand();
      op.ncs = tmp[15:0];
      saved_neip = op.neip;
      drive(op, 1'b1);
      check_word("eip", 64'(eip), 64'(op.neip));
      // an invalid save must not overwrite
      op.valid = 1'b0;
      op.neip = next_rand();
      op.ncs = ~tmp[15:0];
      drive(op, 1'b1);
      op = valid_op();
      op.ctrl.use_temp_neip = 1'b1;
      op.ctrl.use_temp_ncs = 1'b1;
      op.ctrl.ld_eip = 1'b1;
      op.ctrl.ld_cs = 1'b1;
      op.neip = next_rand();
      drive(op, 1'b1);
      check_word("eip", 64'(eip), 64'(saved_neip));
      check_word("cs", 64'(cs), 64'(tmp[15:0]));
      check_word("ld_eip", 64'(ld_eip), 64'd1);
      check_word("ld_cs", 64'(ld_cs), 64'd1);
      op = valid_op();
      op.ctrl.is_halt = 1'b1;
      drive(op, 1'b1);
      check_word("halt", 64'(halt), 64'd1);
      op.valid = 1'b0;
      drive(op, 1'b1);
      check_word("halt", 64'(halt), 64'd0);
   endtask

   task automatic test_backpressure();
      wb_pkg::wb_in_t     st;
      wb_pkg::wb_in_t     jmp;
      wb_pkg::wb_commit_t exp_c;
      load_flags(32'h2);
      st = valid_op();
      st.dcache_write = 1'b1;
      st.ctrl.ld_flags = 1'b1;
      st.flags.raw = 32'h40;
      st.address = next_rand();
      exp_c = '0;
      exp_c.ld_flags = 1'b1;
      exp_c.dcache_write = 1'b1;
      repeat (3) begin
         drive(st, 1'b0);
         check_word("stall", 64'(stall), 64'd1);
         check_commit("dep", dep, exp_c);
      end
      jmp = valid_op();
      jmp.ctrl.is_jne = 1'b1;
      jmp.ctrl.ld_eip = 1'b1;
      // zf still clear, so the held store wrote nothing
      drive(jmp, 1'b0);
      check_word("stall", 64'(stall), 64'd0);
      check_word("ld_eip", 64'(ld_eip), 64'd1);
      drive(st, 1'b1);
      check_word("stall", 64'(stall), 64'd0);
      model_flags = (st.flags.raw & ALU_MASK) | (model_flags & ~ALU_MASK);
      drive(jmp, 1'b1);
      check_word("ld_eip", 64'(ld_eip), 64'(!model_flags[6]));
   endtask

   initial begin
      arst_n = 1'b0;
      wb_in = '0;
      write_ready = 1'b1;
      rng_state = 32'd2;
      model_flags = 32'h0000_0002;
      repeat (10) @(posedge clk);
      #1;
      arst_n = 1'b1;
      #1;
      check_word("flags_fwd", 64'(flags_fwd.raw), 64'(model_flags));
      check_commit("dep", dep, '0);
      test_alu_mem();
      test_flags();
      test_conditions();
      test_cmps();
      test_saved_and_halt();
      test_backpressure();
      drive('0, 1'b1);
      @(posedge clk);
      #1;
      if (i_dut.u_chk.stall_fails + i_dut.u_chk.idle_fails + i_dut.u_chk.reset_fails == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         $display("CHECKS FAILED");
         $fatal(1, "bound assertions reported failures");
      end
   end

endmodule

//--- verif/wb_chk.sv
`timescale 1ns/1ps

module wb_chk (
   input logic               clk,
   input logic               arst_n,
   input wb_pkg::wb_in_t     wb_in,
   input wb_pkg::wb_commit_t dep,
   input logic               halt,
   input logic               stall
);

   int   stall_fails = 0;
   int   idle_fails = 0;
   int   reset_fails = 0;
   logic seen_valid;

   // first valid micro-op since reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         seen_valid <= 1'b0;
      end else if (wb_in.valid) begin
         seen_valid <= 1'b1;
      end
   end

   stall_needs_store: assert property (@(posedge clk) disable iff (!arst_n)
      stall |-> dep.dcache_write)
   else begin
      stall_fails = stall_fails + 1;
      $error("stall high without a committed store");
   end

   idle_no_loads: assert property (@(posedge clk) disable iff (!arst_n)
      !wb_in.valid |-> dep == '0)
   else begin
      idle_fails = idle_fails + 1;
      $error("load output high while valid is low");
   end

   quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
      !(seen_valid || wb_in.valid) |-> !halt && !stall)
   else begin
      reset_fails = reset_fails + 1;
      $error("halt or stall high before the first valid micro-op");
   end

endmodule

bind writeback wb_chk u_chk (
   .clk    (clk),
   .arst_n (arst_n),
   .wb_in  (wb_in),
   .dep    (dep),
   .halt   (halt),
   .stall  (stall)
);

//--- verilog/wb_commit.sv
`timescale 1ns/1ps

module wb_commit (
   input  logic               [31:0] data1,
   input  wb_pkg::wb_in_t     wb_in,
   input  wb_pkg::wb_flags_u  cur_flags,
   input  wb_pkg::wb_flags_u  final_flags,
   input  logic               write_ready,
   output wb_pkg::wb_commit_t commit,
   output logic               halt,
   output logic               repne_terminate,
   output logic               stall,
   output logic [63:0]        dcache_data
);

   logic cf;
   logic zf;
   logic eip_cond;
   logic gpr2_cond;
   logic count_zero;
   logic qual;

   // conditions see the flags from before this micro-op
   assign cf = cur_flags.bits.cf;
   assign zf = cur_flags.bits.zf;

   always_comb begin
      if (wb_in.ctrl.is_jne) begin
         eip_cond = !zf;
      end else if (wb_in.ctrl.is_jnbe) begin
         eip_cond = !cf && !zf;
      end else begin
         eip_cond = 1'b1;
      end
   end

   // cmovc only moves on carry
   assign gpr2_cond = wb_in.ctrl.is_cmovc ? cf : 1'b1;

   // repne cmps stops on a match or when ecx runs out
   assign count_zero = (wb_in.result_c == 32'd0);

   assign repne_terminate = wb_in.valid &&
                            wb_in.ctrl.is_cmps_second &&
                            wb_in.repne &&
                            (final_flags.bits.zf || count_zero);

   assign halt = wb_in.valid && wb_in.ctrl.is_halt;

   // nothing architectural happens on an invalid or terminated pass
   assign qual = wb_in.valid && !repne_terminate;

   always_comb begin
      commit.ld_gpr1      = qual && wb_in.ld_gpr1;
      commit.ld_gpr2      = qual && wb_in.ld_gpr2 && gpr2_cond;
      commit.ld_gpr3      = qual && wb_in.ctrl.ld_gpr3;
      commit.ld_seg       = qual && wb_in.ctrl.ld_seg;
      commit.ld_mm        = qual && wb_in.ctrl.ld_mm;
      commit.ld_flags     = qual && wb_in.ctrl.ld_flags;
      commit.ld_eip       = qual && wb_in.ctrl.ld_eip && eip_cond;
      commit.ld_cs        = qual && wb_in.ctrl.ld_cs;
      commit.dcache_write = qual && wb_in.dcache_write;
   end

   // mmx stores write the full quadword
   always_comb begin
      if (wb_in.ctrl.mm_mem) begin
         dcache_data = wb_in.result_mm;
      end else begin
         dcache_data = {32'd0, data1};
      end
   end

   // hold the stage while the cache cannot take the store
   assign stall = commit.dcache_write && !write_ready;

endmodule

//--- verilog/wb_flags.sv
`timescale 1ns/1ps

module wb_flags (
   input  logic              clk,
   input  logic              arst_n,
   input  wb_pkg::wb_in_t    wb_in,
   input  logic              commit_ld_flags,
   input  logic              stall,
   output wb_pkg::wb_flags_u cur_flags,
   output wb_pkg::wb_flags_u final_flags
);

   wb_pkg::wb_flags_u flags_q;
   wb_pkg::wb_flags_u merged;

   // ALU owns the mask bits, everything else is kept
   always_comb begin
      merged.raw = (wb_in.flags.raw & wb_pkg::WB_FLAGS_MASK) |
                   (flags_q.raw & ~wb_pkg::WB_FLAGS_MASK);
   end

   // popf takes the whole word off the stack
   always_comb begin
      if (wb_in.ctrl.pop_flags) begin
         final_flags.raw = wb_in.result_a;
      end else begin
         final_flags = merged;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         flags_q.raw <= wb_pkg::WB_FLAGS_RESET;
      end else if (commit_ld_flags && !stall) begin
         flags_q <= final_flags;
      end
   end

   assign cur_flags = flags_q;

endmodule

//--- verilog/wb_operand_select.sv
`timescale 1ns/1ps

module wb_operand_select (
   input  logic              clk,
   input  logic              arst_n,
   input  wb_pkg::wb_in_t    wb_in,
   input  wb_pkg::wb_flags_u final_flags,
   input  logic              stall,
   output logic [31:0]       data1,
   output logic [31:0]       eip,
   output logic [15:0]       cs,
   output logic [31:0]       count
);

   logic [31:0] temp_q;
   logic [31:0] neip_q;
   logic [15:0] ncs_q;
   logic        advance;

   // a valid micro-op that is not held by the cache
   assign advance = wb_in.valid && !stall;

   // first CMPS operand, consumed by the second micro-op
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         temp_q <= '0;
      end else if (advance && wb_in.ctrl.is_cmps_first) begin
         temp_q <= wb_in.result_a;
      end
   end

   // return address for far transfers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         neip_q <= '0;
         ncs_q  <= '0;
      end else begin
         if (advance && wb_in.ctrl.save_neip) begin
            neip_q <= wb_in.neip;
         end
         if (advance && wb_in.ctrl.save_ncs) begin
            ncs_q <= wb_in.ncs;
         end
      end
   end

   always_comb begin
      if (wb_in.ctrl.is_cmps_second) begin
         data1 = temp_q;
      end else if (wb_in.ctrl.push_flags) begin
         data1 = final_flags.raw;
      end else begin
         data1 = wb_in.result_a;
      end
   end

   assign eip   = wb_in.ctrl.use_temp_neip ? neip_q : wb_in.neip;
   assign cs    = wb_in.ctrl.use_temp_ncs ? ncs_q : wb_in.ncs;
   assign count = wb_in.result_c;

endmodule

//--- verilog/wb_pkg.sv
package wb_pkg;

   // ALU-writable EFLAGS bits: of, sf, zf, af, pf, cf
   localparam logic [31:0] WB_FLAGS_MASK = 32'h0000_08d5;

   // port 3 always writes a full doubleword
   localparam logic [1:0] WB_DR3_DATASIZE = 2'b10;

   // bit 1 of EFLAGS reads as one
   localparam logic [31:0] WB_FLAGS_RESET = 32'h0000_0002;

   typedef struct packed {
      logic ld_gpr3;
      logic ld_seg;
      logic ld_mm;
      logic ld_flags;
      logic ld_eip;
      logic ld_cs;
      logic pop_flags;
      logic save_neip;
      logic save_ncs;
      logic use_temp_neip;
      logic use_temp_ncs;
      logic is_cmps_first;
      logic is_cmps_second;
      logic is_halt;
      logic is_jne;
      logic is_jnbe;
      logic is_cmovc;
      logic mm_mem;
      logic push_flags;
      logic spare;
   } wb_ctrl_t;

   typedef struct packed {
      logic [24:0] rsvd_31_7;
      logic        zf;
      logic [4:0]  rsvd_5_1;
      logic        cf;
   } wb_eflags_t;

   // raw word for push/pop, named bits for conditions
   typedef union packed {
      logic [31:0] raw;
      wb_eflags_t  bits;
   } wb_flags_u;

   typedef struct packed {
      logic        valid;
      logic [31:0] neip;
      logic [15:0] ncs;
      wb_ctrl_t    ctrl;
      logic [1:0]  datasize;
      logic        ld_gpr1;
      logic        ld_gpr2;
      logic        dcache_write;
      logic        repne;
      logic [31:0] result_a;
      logic [31:0] result_b;
      logic [31:0] result_c;
      wb_flags_u   flags;
      logic [63:0] result_mm;
      logic [2:0]  dr1;
      logic [2:0]  dr2;
      logic [2:0]  dr3;
      logic [31:0] address;
   } wb_in_t;

   typedef struct packed {
      logic        ld;
      logic [2:0]  dr;
      logic [31:0] data;
   } wb_gpr_wr_t;

   typedef struct packed {
      logic ld_gpr1;
      logic ld_gpr2;
      logic ld_gpr3;
      logic ld_seg;
      logic ld_mm;
      logic ld_flags;
      logic ld_eip;
      logic ld_cs;
      logic dcache_write;
   } wb_commit_t;

endpackage

//--- verilog/writeback.sv
`timescale 1ns/1ps

module writeback (
   input  logic               clk,
   input  logic               arst_n,
   input  wb_pkg::wb_in_t     wb_in,
   input  logic               write_ready,

   output wb_pkg::wb_gpr_wr_t gpr1,
   output wb_pkg::wb_gpr_wr_t gpr2,
   output wb_pkg::wb_gpr_wr_t gpr3,
   output logic [1:0]         datasize,
   output logic [1:0]         dr3_datasize,
   output logic               ld_seg,
   output logic [63:0]        mm_data,
   output logic               ld_mm,
   output logic [31:0]        eip,
   output logic               ld_eip,
   output logic [15:0]        cs,
   output logic               ld_cs,
   output wb_pkg::wb_flags_u  flags_out,
   output logic               ld_flags,
   output logic [63:0]        dcache_data,
   output logic [31:0]        dcache_address,
   output logic               dcache_write,

   output wb_pkg::wb_commit_t dep,
   output logic               halt,
   output logic               repne_terminate,
   output logic               stall,
   output wb_pkg::wb_flags_u  flags_fwd,
   output logic [31:0]        count_fwd
);

   wb_pkg::wb_flags_u  cur_flags;
   wb_pkg::wb_flags_u  final_flags;
   wb_pkg::wb_commit_t commit;
   logic [31:0]        data1;
   logic [31:0]        count;

   wb_flags u_flags (
      .clk             (clk),
      .arst_n          (arst_n),
      .wb_in           (wb_in),
      .commit_ld_flags (commit.ld_flags),
      .stall           (stall),
      .cur_flags       (cur_flags),
      .final_flags     (final_flags)
   );

   wb_operand_select u_operand_select (
      .clk         (clk),
      .arst_n      (arst_n),
      .wb_in       (wb_in),
      .final_flags (final_flags),
      .stall       (stall),
      .data1       (data1),
      .eip         (eip),
      .cs          (cs),
      .count       (count)
   );

   wb_commit u_commit (
      .data1           (data1),
      .wb_in           (wb_in),
      .cur_flags       (cur_flags),
      .final_flags     (final_flags),
      .write_ready     (write_ready),
      .commit          (commit),
      .halt            (halt),
      .repne_terminate (repne_terminate),
      .stall           (stall),
      .dcache_data     (dcache_data)
   );

   // register file write ports
   assign gpr1         = '{ld: commit.ld_gpr1, dr: wb_in.dr1, data: data1};
   assign gpr2         = '{ld: commit.ld_gpr2, dr: wb_in.dr2, data: wb_in.result_b};
   assign gpr3         = '{ld: commit.ld_gpr3, dr: wb_in.dr3, data: wb_in.result_c};
   assign datasize     = wb_in.datasize;
   assign dr3_datasize = wb_pkg::WB_DR3_DATASIZE;

   assign ld_seg   = commit.ld_seg;
   assign mm_data  = wb_in.result_mm;
   assign ld_mm    = commit.ld_mm;
   assign ld_eip   = commit.ld_eip;
   assign ld_cs    = commit.ld_cs;
   assign ld_flags = commit.ld_flags;

   // flags register and the forward path share one value
   assign flags_out = final_flags;
   assign flags_fwd = final_flags;

   assign dcache_address = wb_in.address;
   assign dcache_write   = commit.dcache_write;

   // dependency checks upstream see the qualified loads
   assign dep       = commit;
   assign count_fwd = count;

endmodule
